//--- src/bank_cfg.svh
`ifndef BANK_CFG_SVH
`define BANK_CFG_SVH

// data path width
`define BG_DATA_W     32

// host address: bit 0 picks the bank, upper bits pick the random word
`define BG_HOST_AW    7

// one bank holds 256 words
`define BG_BANK_AW    8

// entries per queue, half of them in each bank
`define BG_FIFO_DEPTH 128

// per-bank region bases
`define BG_Q0_BASE    (0 * (`BG_FIFO_DEPTH / 2))
`define BG_Q1_BASE    (1 * (`BG_FIFO_DEPTH / 2))
`define BG_Q2_BASE    (2 * (`BG_FIFO_DEPTH / 2))
`define BG_RAND_BASE  (3 * (`BG_FIFO_DEPTH / 2))

`endif

//--- src/bank_pkg.sv
`default_nettype none

package bank_pkg;

    // host mode, sampled from mode_i
    typedef enum logic {
        MODE_RANDOM = 1'b0,
        MODE_FIFO   = 1'b1
    } bg_mode_e;

    // queue select, code 3 selects nothing
    typedef enum logic [1:0] {
        Q0     = 2'd0,
        Q1     = 2'd1,
        Q2     = 2'd2,
        Q_NONE = 2'd3
    } bg_queue_e;

    // what one queue controller does this cycle
    typedef enum logic [1:0] {
        ACC_IDLE  = 2'd0,
        ACC_READ  = 2'd1,
        ACC_WRITE = 2'd2
    } bg_access_e;

endpackage

`default_nettype wire

//--- src/bank_req_if.sv
`default_nettype none
`include "bank_cfg.svh"

interface bank_req_if;

    logic                   en;
    logic                   we;
    logic [`BG_BANK_AW-1:0] addr;
    logic [`BG_DATA_W-1:0]  wdata;

    // arbiter side drives the request
    modport req (
        output en,
        output we,
        output addr,
        output wdata
    );

    // memory side samples it
    modport mem (
        input en,
        input we,
        input addr,
        input wdata
    );

endinterface

`default_nettype wire

//--- src/fifo_ctrl.sv
`default_nettype none
`include "bank_cfg.svh"

module fifo_ctrl import bank_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en_i,
    input  logic                   we_i,
    input  logic                   re_i,
    input  logic                   flush_i,
    output logic                   b0_en_o,
    output logic                   b0_we_o,
    output logic [`BG_BANK_AW-1:0] b0_addr_o,
    output logic                   b1_en_o,
    output logic                   b1_we_o,
    output logic [`BG_BANK_AW-1:0] b1_addr_o
);

    localparam int ptr_w = $clog2(`BG_FIFO_DEPTH);
    localparam logic [ptr_w:0] depth = `BG_FIFO_DEPTH;

    logic [ptr_w-1:0]       wr_ptr;
    logic [ptr_w-1:0]       rd_ptr;
    logic [ptr_w-1:0]       act_ptr;
    logic [ptr_w:0]         count;
    logic [`BG_BANK_AW-1:0] word_addr;
    bg_access_e             access;

    // write wins over read, flush blocks both
    always_comb begin
        access = ACC_IDLE;
        if (en_i && !flush_i) begin
            if (we_i) begin
                if (count < depth) begin
                    access = ACC_WRITE;
                end
            end else if (re_i && (count != '0)) begin
                access = ACC_READ;
            end
        end
    end

    // low pointer bit picks the bank, the rest is the word
    assign act_ptr   = (access == ACC_WRITE) ? wr_ptr : rd_ptr;
    assign word_addr = {{(`BG_BANK_AW - ptr_w + 1){1'b0}}, act_ptr[ptr_w-1:1]};

    always_comb begin
        b0_en_o = (access != ACC_IDLE) && !act_ptr[0];
        b1_en_o = (access != ACC_IDLE) && act_ptr[0];
        b0_we_o = b0_en_o && (access == ACC_WRITE);
        b1_we_o = b1_en_o && (access == ACC_WRITE);
    end

    // queue-local, the arbiter adds the region base
    assign b0_addr_o = word_addr;
    assign b1_addr_o = word_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (en_i && flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            case (access)
                ACC_WRITE: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    count  <= count + 1'b1;
                end
                ACC_READ: begin
                    rd_ptr <= rd_ptr + 1'b1;
                    count  <= count - 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/bank_arbiter.sv
`default_nettype none
`include "bank_cfg.svh"

module bank_arbiter import bank_pkg::*; (
    input  bg_mode_e               mode_i,
    input  bg_queue_e              queue_i,
    input  logic                   en_i,
    input  logic                   we_i,
    input  logic [`BG_HOST_AW-1:0] addr_i,
    input  logic [`BG_DATA_W-1:0]  wdata_i,
    input  logic                   q0_b0_en_i,
    input  logic                   q0_b0_we_i,
    input  logic [`BG_BANK_AW-1:0] q0_b0_addr_i,
    input  logic                   q0_b1_en_i,
    input  logic                   q0_b1_we_i,
    input  logic [`BG_BANK_AW-1:0] q0_b1_addr_i,
    input  logic                   q1_b0_en_i,
    input  logic                   q1_b0_we_i,
    input  logic [`BG_BANK_AW-1:0] q1_b0_addr_i,
    input  logic                   q1_b1_en_i,
    input  logic                   q1_b1_we_i,
    input  logic [`BG_BANK_AW-1:0] q1_b1_addr_i,
    input  logic                   q2_b0_en_i,
    input  logic                   q2_b0_we_i,
    input  logic [`BG_BANK_AW-1:0] q2_b0_addr_i,
    input  logic                   q2_b1_en_i,
    input  logic                   q2_b1_we_i,
    input  logic [`BG_BANK_AW-1:0] q2_b1_addr_i,
    bank_req_if.req                bank0,
    bank_req_if.req                bank1
);

    localparam logic [`BG_BANK_AW-1:0] q_base [3] = '{`BG_Q0_BASE, `BG_Q1_BASE, `BG_Q2_BASE};
    localparam logic [`BG_BANK_AW-1:0] rand_base = `BG_RAND_BASE;

    logic [2:0]             b0_en_q;
    logic [2:0]             b0_we_q;
    logic [2:0]             b1_en_q;
    logic [2:0]             b1_we_q;
    logic [`BG_BANK_AW-1:0] b0_addr_q [3];
    logic [`BG_BANK_AW-1:0] b1_addr_q [3];
    logic [`BG_BANK_AW-1:0] rand_addr;
    logic [1:0]             sel;

    // gather the queue requests so the selected one can be indexed
    assign b0_en_q   = {q2_b0_en_i, q1_b0_en_i, q0_b0_en_i};
    assign b0_we_q   = {q2_b0_we_i, q1_b0_we_i, q0_b0_we_i};
    assign b1_en_q   = {q2_b1_en_i, q1_b1_en_i, q0_b1_en_i};
    assign b1_we_q   = {q2_b1_we_i, q1_b1_we_i, q0_b1_we_i};
    assign b0_addr_q = '{q0_b0_addr_i, q1_b0_addr_i, q2_b0_addr_i};
    assign b1_addr_q = '{q0_b1_addr_i, q1_b1_addr_i, q2_b1_addr_i};
    assign sel       = queue_i;

    // host word sits in the top region of either bank
    assign rand_addr = {{(`BG_BANK_AW - `BG_HOST_AW + 1){1'b0}}, addr_i[`BG_HOST_AW-1:1]}
                       + rand_base;

    always_comb begin
        bank0.en   = 1'b0;
        bank0.we   = 1'b0;
        bank0.addr = '0;
        bank1.en   = 1'b0;
        bank1.we   = 1'b0;
        bank1.addr = '0;
        if (mode_i == MODE_FIFO) begin
            // Q_NONE leaves both banks idle
            if (queue_i != Q_NONE) begin
                bank0.en   = b0_en_q[sel];
                bank0.we   = b0_we_q[sel];
                bank0.addr = b0_addr_q[sel] + q_base[sel];
                bank1.en   = b1_en_q[sel];
                bank1.we   = b1_we_q[sel];
                bank1.addr = b1_addr_q[sel] + q_base[sel];
            end
        end else begin
            bank0.en   = en_i && !addr_i[0];
            bank0.we   = we_i;
            bank0.addr = rand_addr;
            bank1.en   = en_i && addr_i[0];
            bank1.we   = we_i;
            bank1.addr = rand_addr;
        end
    end

    // same write data to both banks
    assign bank0.wdata = wdata_i;
    assign bank1.wdata = wdata_i;

endmodule

`default_nettype wire

//--- src/sram_sp.sv
`default_nettype none
`include "bank_cfg.svh"

module sram_sp (
    input  logic                  clk,
    bank_req_if.mem               req,
    output logic [`BG_DATA_W-1:0] rdata_o
);

    localparam int words = 2 ** `BG_BANK_AW;

    logic [`BG_DATA_W-1:0] mem [words];

    // one access per cycle, write or read
    always_ff @(posedge clk) begin
        if (req.en) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                // read data holds until the next read
                rdata_o <= mem[req.addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/bankgroup.sv
`default_nettype none
`include "bank_cfg.svh"

module bankgroup import bank_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en_i,
    input  logic                   we_i,
    input  logic                   re_i,
    input  logic                   flush_i,
    input  logic                   mode_i,
    input  logic [1:0]             queue_i,
    input  logic [`BG_HOST_AW-1:0] addr_i,
    input  logic [`BG_DATA_W-1:0]  din_i,
    output logic                   dout_valid_o,
    output logic [`BG_DATA_W-1:0]  dout_o
);

    logic                   en_q;
    logic                   we_q;
    logic                   re_q;
    logic                   flush_q;
    bg_mode_e               mode_q;
    bg_queue_e              queue_q;
    logic [`BG_HOST_AW-1:0] addr_q;
    logic [`BG_DATA_W-1:0]  din_q;

    logic [2:0]             q_en;
    logic [2:0]             q_b0_en;
    logic [2:0]             q_b0_we;
    logic [2:0]             q_b1_en;
    logic [2:0]             q_b1_we;
    logic [`BG_BANK_AW-1:0] q_b0_addr [3];
    logic [`BG_BANK_AW-1:0] q_b1_addr [3];

    logic [`BG_DATA_W-1:0]  rdata0;
    logic [`BG_DATA_W-1:0]  rdata1;
    logic                   rvalid0;
    logic                   rvalid1;

    // host input register, everything below uses these copies
    always_ff @(posedge clk) begin
        if (rst) begin
            en_q    <= 1'b0;
            we_q    <= 1'b0;
            re_q    <= 1'b0;
            flush_q <= 1'b0;
            mode_q  <= MODE_RANDOM;
            queue_q <= Q_NONE;
        end else begin
            en_q    <= en_i;
            we_q    <= we_i;
            re_q    <= re_i;
            flush_q <= flush_i;
            mode_q  <= bg_mode_e'(mode_i);
            queue_q <= bg_queue_e'(queue_i);
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr_i;
        din_q  <= din_i;
    end

    // one controller per queue, enabled only when it is selected in FIFO mode
    for (genvar i = 0; i < 3; i++) begin : g_queue
        assign q_en[i] = (mode_q == MODE_FIFO) && (queue_q == bg_queue_e'(i));

        fifo_ctrl u_fifo (
            .clk       (clk),
            .rst       (rst),
            .en_i      (q_en[i]),
            .we_i      (we_q),
            .re_i      (re_q),
            .flush_i   (flush_q),
            .b0_en_o   (q_b0_en[i]),
            .b0_we_o   (q_b0_we[i]),
            .b0_addr_o (q_b0_addr[i]),
            .b1_en_o   (q_b1_en[i]),
            .b1_we_o   (q_b1_we[i]),
            .b1_addr_o (q_b1_addr[i])
        );
    end

    bank_req_if bank0 ();
    bank_req_if bank1 ();

    bank_arbiter u_arbiter (
        .mode_i       (mode_q),
        .queue_i      (queue_q),
        .en_i         (en_q),
        .we_i         (we_q),
        .addr_i       (addr_q),
        .wdata_i      (din_q),
        .q0_b0_en_i   (q_b0_en[0]),
        .q0_b0_we_i   (q_b0_we[0]),
        .q0_b0_addr_i (q_b0_addr[0]),
        .q0_b1_en_i   (q_b1_en[0]),
        .q0_b1_we_i   (q_b1_we[0]),
        .q0_b1_addr_i (q_b1_addr[0]),
        .q1_b0_en_i   (q_b0_en[1]),
        .q1_b0_we_i   (q_b0_we[1]),
        .q1_b0_addr_i (q_b0_addr[1]),
        .q1_b1_en_i   (q_b1_en[1]),
        .q1_b1_we_i   (q_b1_we[1]),
        .q1_b1_addr_i (q_b1_addr[1]),
        .q2_b0_en_i   (q_b0_en[2]),
        .q2_b0_we_i   (q_b0_we[2]),
        .q2_b0_addr_i (q_b0_addr[2]),
        .q2_b1_en_i   (q_b1_en[2]),
        .q2_b1_we_i   (q_b1_we[2]),
        .q2_b1_addr_i (q_b1_addr[2]),
        .bank0        (bank0),
        .bank1        (bank1)
    );

    sram_sp u_sram0 (
        .clk     (clk),
        .req     (bank0),
        .rdata_o (rdata0)
    );

    sram_sp u_sram1 (
        .clk     (clk),
        .req     (bank1),
        .rdata_o (rdata1)
    );

    // read valid lines up with the registered sram data
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid0 <= 1'b0;
            rvalid1 <= 1'b0;
        end else begin
            rvalid0 <= bank0.en && !bank0.we;
            rvalid1 <= bank1.en && !bank1.we;
        end
    end

    // output stage, all ones when idle
    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid_o <= 1'b0;
            dout_o       <= '1;
        end else if (rvalid0) begin
            dout_valid_o <= 1'b1;
            dout_o       <= rdata0;
        end else if (rvalid1) begin
            dout_valid_o <= 1'b1;
            dout_o       <= rdata1;
        end else begin
            dout_valid_o <= 1'b0;
            dout_o       <= '1;
        end
    end

endmodule

`default_nettype wire

//--- dv/bankgroup_model.sv
`default_nettype none
`include "bank_cfg.svh"

module bankgroup_model import bank_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int depth = `BG_FIFO_DEPTH;

    // random region seen through the host address, bank bit included
    logic [`BG_DATA_W-1:0] rand_mem [2 ** `BG_HOST_AW];

    // one circular buffer per queue
    logic [`BG_DATA_W-1:0] entries [3][depth];
    int                    head [3];
    int                    fill [3];

    // predict the result of one host cycle
    task automatic step(
        input  logic                   mode,
        input  logic [1:0]             queue,
        input  logic                   en,
        input  logic                   we,
        input  logic                   re,
        input  logic                   flush,
        input  logic [`BG_HOST_AW-1:0] addr,
        input  logic [`BG_DATA_W-1:0]  data,
        output logic                   valid,
        output logic [`BG_DATA_W-1:0]  rdata
    );
        int q;
        valid = 1'b0;
        rdata = '1;
        q     = int'(queue);
        if (bg_mode_e'(mode) == MODE_RANDOM) begin
            if (en && we) begin
                rand_mem[addr] = data;
            end else if (en) begin
                valid = 1'b1;
                rdata = rand_mem[addr];
            end
        end else if (bg_queue_e'(queue) != Q_NONE) begin
            // flush first, then write, then read
            if (flush) begin
                head[q] = 0;
                fill[q] = 0;
            end else if (we) begin
                if (fill[q] < depth) begin
                    entries[q][(head[q] + fill[q]) % depth] = data;
                    fill[q]++;
                end
            end else if (re && (fill[q] > 0)) begin
                valid   = 1'b1;
                rdata   = entries[q][head[q]];
                head[q] = (head[q] + 1) % depth;
                fill[q]--;
            end
        end
    endtask

endmodule

`default_nettype wire

//--- dv/bankgroup_tb.sv
`default_nettype none
`include "bank_cfg.svh"

module bankgroup_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_WRITE,
        OP_READ,
        OP_WRRD,
        OP_FLUSH
    } op_e;

    // one table row, repeated reps times with the address stepping
    typedef struct packed {
        op_e        op;
        logic       mode;
        logic [1:0] queue;
        logic [6:0] addr;
        logic [7:0] tag;
        int         reps;
    } step_t;

    localparam logic RND = 1'b0;
    localparam logic FF  = 1'b1;

    logic                   clk;
    logic                   rst;
    logic                   en_i;
    logic                   we_i;
    logic                   re_i;
    logic                   flush_i;
    logic                   mode_i;
    logic [1:0]             queue_i;
    logic [`BG_HOST_AW-1:0] addr_i;
    logic [`BG_DATA_W-1:0]  din_i;
    logic                   dout_valid_o;
    logic [`BG_DATA_W-1:0]  dout_o;

    step_t                 steps [$];
    logic                  exp_valid_q [$];
    logic [`BG_DATA_W-1:0] exp_data_q [$];
    int                    total_steps;
    bit                    table_ready;
    int                    valid_errs;
    int                    data_errs;

    bankgroup u_bankgroup (
        .clk          (clk),
        .rst          (rst),
        .en_i         (en_i),
        .we_i         (we_i),
        .re_i         (re_i),
        .flush_i      (flush_i),
        .mode_i       (mode_i),
        .queue_i      (queue_i),
        .addr_i       (addr_i),
        .din_i        (din_i),
        .dout_valid_o (dout_valid_o),
        .dout_o       (dout_o)
    );

    bankgroup_model u_model ();

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic void add_step(op_e op, logic mode, int queue, int addr, int tag,
                                     int reps);
        step_t s;
        s.op    = op;
        s.mode  = mode;
        s.queue = 2'(queue);
        s.addr  = 7'(addr);
        s.tag   = 8'(tag);
        s.reps  = reps;
        steps.push_back(s);
        total_steps += reps;
    endfunction

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            valid_errs++;
            if (act === 1'b1) begin
                $display("%0t: unexpected valid pulse on dout_valid_o", $time);
            end else begin
                $display("%0t: missing valid pulse on dout_valid_o", $time);
            end
        end
    endtask

    task automatic check_data(input logic [`BG_DATA_W-1:0] exp,
                              input logic [`BG_DATA_W-1:0] act);
        if (act !== exp) begin
            data_errs++;
            $display("MISMATCH %0t dout_o expected %h got %h", $time, exp, act);
        end
    endtask

    // the result of a step shows up three falling edges after it was driven
    task automatic check_due();
        if (exp_valid_q.size() == 3) begin
            check_valid(exp_valid_q.pop_front(), dout_valid_o);
            check_data(exp_data_q.pop_front(), dout_o);
        end
    endtask

    task automatic drive_step(input step_t s, input int i);
        logic [31:0]           rnd;
        logic                  exp_v;
        logic [`BG_DATA_W-1:0] exp_d;
        rnd     = $urandom();
        en_i    = (s.op != OP_IDLE);
        we_i    = (s.op == OP_WRITE) || (s.op == OP_WRRD);
        re_i    = (s.op == OP_READ) || (s.op == OP_WRRD);
        flush_i = (s.op == OP_FLUSH);
        mode_i  = s.mode;
        queue_i = s.queue;
        addr_i  = s.addr + 7'(i);
        din_i   = {s.tag, rnd[23:0]};
        u_model.step(mode_i, queue_i, en_i, we_i, re_i, flush_i, addr_i, din_i, exp_v, exp_d);
        exp_valid_q.push_back(exp_v);
        exp_data_q.push_back(exp_d);
    endtask

    // watchdog
    initial begin
        wait (table_ready);
        repeat (total_steps * 10 + 200) @(posedge clk);
        $display("timeout after %0d cycles, run did not complete", total_steps * 10 + 200);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        step_t idle_s;
        void'($urandom(32'hda45));
        rst     = 1'b1;
        en_i    = 1'b0;
        we_i    = 1'b0;
        re_i    = 1'b0;
        flush_i = 1'b0;
        mode_i  = 1'b0;
        queue_i = 2'd3;
        addr_i  = '0;
        din_i   = '0;
        idle_s  = '0;

        // random region over both banks
        add_step(OP_WRITE, RND, 0, 0, 8'h10, 128);
        add_step(OP_IDLE,  RND, 0, 0, 0,     4);
        add_step(OP_READ,  RND, 0, 0, 0,     128);
        // queue order, other queues written in between
        add_step(OP_WRITE, FF,  0, 0, 8'h20, 20);
        add_step(OP_WRITE, FF,  1, 0, 8'h21, 20);
        add_step(OP_WRITE, FF,  2, 0, 8'h22, 20);
        add_step(OP_READ,  FF,  0, 0, 0,     10);
        add_step(OP_WRITE, FF,  1, 0, 8'h23, 3);
        add_step(OP_READ,  FF,  0, 0, 0,     10);
        add_step(OP_READ,  FF,  1, 0, 0,     23);
        add_step(OP_READ,  FF,  2, 0, 0,     20);
        // full and empty on queue 1
        add_step(OP_WRITE, FF,  1, 0, 8'h30, 130);
        add_step(OP_READ,  FF,  1, 0, 0,     130);
        add_step(OP_READ,  FF,  1, 0, 0,     5);
        // flush queue 2 with data pending
        add_step(OP_WRITE, FF,  2, 0, 8'h40, 10);
        add_step(OP_FLUSH, FF,  2, 0, 0,     1);
        add_step(OP_READ,  FF,  2, 0, 0,     3);
        add_step(OP_WRITE, FF,  2, 0, 8'h41, 6);
        add_step(OP_READ,  FF,  2, 0, 0,     6);
        // queue 0 survives random traffic
        add_step(OP_WRITE, FF,  0, 0, 8'h50, 40);
        add_step(OP_WRITE, RND, 0, 0, 8'h51, 128);
        add_step(OP_READ,  RND, 0, 0, 0,     128);
        add_step(OP_WRRD,  FF,  0, 0, 8'h52, 4);
        add_step(OP_READ,  FF,  0, 0, 0,     44);
        add_step(OP_WRITE, FF,  3, 0, 8'h53, 4);
        add_step(OP_READ,  FF,  3, 0, 0,     4);
        add_step(OP_READ,  FF,  0, 0, 0,     2);
        add_step(OP_IDLE,  FF,  0, 0, 0,     6);
        table_ready = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (steps[r]) begin
            for (int i = 0; i < steps[r].reps; i++) begin
                @(negedge clk);
                check_due();
                drive_step(steps[r], i);
            end
        end
        repeat (4) begin
            @(negedge clk);
            check_due();
            drive_step(idle_s, 0);
        end

        $display("errors: valid %0d, data %0d", valid_errs, data_errs);
        if (valid_errs == 0 && data_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+src
src/bank_pkg.sv
src/bank_req_if.sv
src/fifo_ctrl.sv
src/bank_arbiter.sv
src/sram_sp.sv
src/bankgroup.sv
dv/bankgroup_model.sv
dv/bankgroup_tb.sv

//--- Makefile
TOP := bankgroup_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f src.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
